// ==== test/tiny16_input.hex ====
// Word: kind[31:28] n[27:24] payload[23:0]. 1 org addr, 2 code n bytes, 3 irq after n writes,
// 4 expected write (n = in_interrupt, port, data), 5 run image (bit1 error, bit0 hlt), 0 end.
10000000
2380000B 235009BE 23EF6040 2309C250 23011234 235002F0 230F1003 23011203
23026001 23031103 23016002 23031403 23026003 23031303 23016004 23031503
23026005 23031603 23026006 23031703 23016007 23030403 23600803 23050360
23090302 2303600A 23030303 23600B03 23060360 230C0308 2303600D 23030903
23600E03 23070360 230F031E 230301A4 23036010 23011E01 2303A403 23601102
23AA0360 231202A9 23036013 23023004 23856020 23048000 238E6022 2302C160
232304C0
30000012
40010243 40021478 40032469 40041234 40051004 4006F00F 4007E23B 40081DC4
4009E23C 400AE23D 400BE23C 400CC478 400D88F1 400EC478 400F623C 40101234
4013F00F 4020FF85 4140BEEF 4023FF85
50000001
10000000 23500100 232A6005 2301E060 22060100
4005002A
50000002
00000000

// ==== src.f ====
hw/tiny16_pkg.sv
hw/tiny16_alu.sv
hw/tiny16_regs.sv
hw/tiny16_core.sv
hw/code_ram.sv
hw/ram_arbiter.sv
hw/tiny16_soc.sv
test/tiny16_chk.sv
test/tiny16_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timing
TOP       = tiny16_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tiny16_tb.sv ====
`default_nettype none

module tiny16_tb;
    import tiny16_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_RECS   = 256;
    localparam int MAX_EXP    = 64;
    localparam int MAX_BYTES  = 512;
    localparam int TAIL_CYCLES = 50;
    localparam int IRQ_DELAY  = 20;

    logic        clk;
    logic        nreset;
    ram_req_t    host_req;
    logic        interrupt;
    logic [15:0] data_in;
    io_out_t     io_out;
    logic        hlt;
    logic        wfi;
    logic        error;
    logic        in_interrupt;

    logic [31:0] recs [MAX_RECS];
    logic [7:0]  exp_port [MAX_EXP];
    logic [15:0] exp_data [MAX_EXP];
    logic        exp_irq [MAX_EXP];
    logic [12:0] img_addr [MAX_BYTES];
    logic [7:0]  img_byte [MAX_BYTES];

    int exp_total       = 0;
    int out_idx         = 0;
    int mismatch_count  = 0;
    int fail_count      = 0;
    int watchdog_cycles = 0;
    int img_len         = 0;
    int burst_left      = 0;

    tiny16_soc #(
        .RAM_BITS(13)
    ) uut (
        .clk         (clk),
        .nreset      (nreset),
        .host_req    (host_req),
        .interrupt   (interrupt),
        .data_in     (data_in),
        .io_out      (io_out),
        .hlt         (hlt),
        .wfi         (wfi),
        .error       (error),
        .in_interrupt(in_interrupt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ****************************************
    // I/O write monitor.
    // ****************************************

    always @(negedge clk) begin
        if (nreset && io_out.strobe) begin
            assert (out_idx < exp_total)
                else begin
                    $display("Unexpected I/O write to port %h with data %h",
                             io_out.address, io_out.data);
                    mismatch_count++;
                end
            // No I/O write while waiting for an interrupt.
            assert (!wfi)
                else begin
                    $display("MISMATCH wfi: got %h, expected %h", wfi, 1'b0);
                    mismatch_count++;
                end
            if (out_idx < exp_total) begin
                assert (io_out.address == exp_port[out_idx])
                    else begin
                        $display("MISMATCH io_out.address: got %h, expected %h",
                                 io_out.address, exp_port[out_idx]);
                        mismatch_count++;
                    end
                assert (io_out.data == exp_data[out_idx])
                    else begin
                        $display("MISMATCH io_out.data: got %h, expected %h",
                                 io_out.data, exp_data[out_idx]);
                        mismatch_count++;
                    end
                assert (in_interrupt == exp_irq[out_idx])
                    else begin
                        $display("MISMATCH in_interrupt: got %h, expected %h",
                                 in_interrupt, exp_irq[out_idx]);
                        mismatch_count++;
                    end
            end
            out_idx++;
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: programs did not finish within %0d cycles", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    // ****************************************
    // Helpers.
    // ****************************************

    function automatic ram_req_t write_req(input logic [12:0] addr, input logic [7:0] data);
        ram_req_t req;
        req       = '0;
        req.valid = 1'b1;
        req.write = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        return req;
    endfunction

    // Writes into the unused top half of the RAM.
    task automatic drive_host_noise();
        if (burst_left > 0) begin
            host_req <= write_req(13'h1000 | 13'($urandom % 4096), 8'($urandom));
            burst_left--;
        end else begin
            host_req <= '0;
            if ($urandom % 8 == 0) begin
                burst_left = 1 + int'($urandom % 4);
            end
        end
    endtask

    task automatic run_program(input logic exp_hlt, input logic exp_error,
                               input int irq_after, input int base);
        int   tail;
        int   irq_wait;
        logic irq_done;
        logic waiting;
        logic stopped;
        logic hlt_s;
        logic err_s;
        logic in_irq_s;
        tail       = 0;
        irq_wait   = 0;
        irq_done   = irq_after < 0;
        waiting    = 1'b0;
        stopped    = 1'b0;
        hlt_s      = 1'b0;
        err_s      = 1'b0;
        in_irq_s   = 1'b0;
        burst_left = 0;
        @(posedge clk);
        nreset    <= 1'b0;
        host_req  <= '0;
        interrupt <= 1'b0;
        repeat (10) @(posedge clk);
        // Host holds the RAM so the core stalls on address 0.
        for (int i = 0; i < img_len; i++) begin
            nreset   <= 1'b1;
            host_req <= write_req(img_addr[i], img_byte[i]);
            @(posedge clk);
        end
        while (tail < TAIL_CYCLES) begin
            drive_host_noise();
            interrupt <= 1'b0;
            if (!irq_done && waiting) begin
                irq_wait++;
                if (irq_wait == IRQ_DELAY) begin
                    interrupt <= 1'b1;
                    irq_done = 1'b1;
                end
            end
            @(negedge clk);
            waiting  = wfi && out_idx == base + irq_after;
            hlt_s    = hlt;
            err_s    = error;
            in_irq_s = in_interrupt;
            if (hlt || error) begin
                stopped = 1'b1;
            end
            if (stopped) begin
                tail++;
            end
            @(posedge clk);
        end
        host_req <= '0;
        assert (out_idx == exp_total)
            else begin
                $display("Program stopped after %0d of %0d expected I/O writes",
                         out_idx - base, exp_total - base);
                fail_count++;
            end
        assert (hlt_s == exp_hlt)
            else begin
                $display("MISMATCH hlt: got %h, expected %h", hlt_s, exp_hlt);
                fail_count++;
            end
        assert (err_s == exp_error)
            else begin
                $display("MISMATCH error: got %h, expected %h", err_s, exp_error);
                fail_count++;
            end
        assert (!in_irq_s)
            else begin
                $display("MISMATCH in_interrupt: got %h, expected %h", in_irq_s, 1'b0);
                fail_count++;
            end
    endtask

    // ****************************************
    // Main sequence.
    // ****************************************

    initial begin
        int          seed_val;
        int          idx;
        int          n_writes;
        int          irq_after;
        int          base;
        int          cnt;
        logic        done;
        logic [3:0]  kind;
        logic [12:0] org;
        nreset    = 1'b0;
        host_req  = '0;
        interrupt = 1'b0;
        data_in   = 16'h0000;
        seed_val  = $urandom(32'h00b0_1e24);
        for (int i = 0; i < MAX_RECS; i++) begin
            recs[i] = '0;
        end
        $readmemh("test/tiny16_input.hex", recs);
        n_writes = 0;
        for (int i = 0; i < MAX_RECS; i++) begin
            if (recs[i][31:28] == 4'd4) begin
                n_writes++;
            end
        end
        watchdog_cycles = n_writes * 400 + 2000;
        idx       = 0;
        irq_after = -1;
        base      = 0;
        org       = '0;
        done      = 1'b0;
        while (!done && idx < MAX_RECS) begin
            kind = recs[idx][31:28];
            cnt  = int'(recs[idx][27:24]);
            case (kind)
                4'd0: done = 1'b1;
                4'd1: org = recs[idx][12:0];
                4'd2: begin
                    for (int b = 0; b < cnt; b++) begin
                        img_addr[img_len] = org;
                        img_byte[img_len] = recs[idx][23 - 8 * b -: 8];
                        org = org + 13'd1;
                        img_len++;
                    end
                end
                4'd3: irq_after = int'(recs[idx][15:0]);
                4'd4: begin
                    exp_port[exp_total] = recs[idx][23:16];
                    exp_data[exp_total] = recs[idx][15:0];
                    exp_irq[exp_total]  = recs[idx][24];
                    exp_total++;
                end
                4'd5: begin
                    run_program(recs[idx][0], recs[idx][1], irq_after, base);
                    base      = exp_total;
                    irq_after = -1;
                    img_len   = 0;
                end
                default: begin
                    $display("Unknown record kind %h in the data file", kind);
                    fail_count++;
                end
            endcase
            idx++;
        end
        $display("Errors: %0d I/O mismatches, %0d other failures",
                 mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/tiny16_chk.sv ====
`default_nettype none

module tiny16_chk (
    input wire                       clk,
    input wire                       nreset,
    input wire tiny16_pkg::ram_req_t host_req,
    input wire                       core_rvalid,
    input wire tiny16_pkg::io_out_t  io_out,
    input wire                       hlt,
    input wire                       error
);

    // A host cycle hands no read byte to the core.
    host_first: assert property (@(posedge clk) disable iff (!nreset)
        host_req.valid |=> !core_rvalid)
        else $error("Core got a read byte for a cycle in which the host held the code RAM");

    strobe_pulse: assert property (@(posedge clk) disable iff (!nreset)
        io_out.strobe |=> !io_out.strobe)
        else $error("I/O strobe stayed high for two cycles");

    stop_cause: assert property (@(posedge clk) disable iff (!nreset)
        !(hlt && error))
        else $error("Halt and error flags set together");

endmodule

bind tiny16_soc tiny16_chk u_chk (
    .clk        (clk),
    .nreset     (nreset),
    .host_req   (host_req),
    .core_rvalid(core_rvalid),
    .io_out     (io_out),
    .hlt        (hlt),
    .error      (error)
);

`default_nettype wire

// ==== hw/tiny16_soc.sv ====
`default_nettype none

module tiny16_soc #(
    parameter int RAM_BITS = 13
) (
    input  wire                       clk,
    input  wire                       nreset,
    input  wire tiny16_pkg::ram_req_t host_req,
    input  wire                       interrupt,
    input  wire [15:0]                data_in,
    output tiny16_pkg::io_out_t       io_out,
    output logic                      hlt,
    output logic                      wfi,
    output logic                      error,
    output logic                      in_interrupt
);
    import tiny16_pkg::*;

    ram_req_t    core_req;
    ram_req_t    ram_req;
    reg_wr_t     reg_wr;
    alu_op_e     alu_op;
    logic        core_gnt;
    logic        core_rvalid;
    logic [7:0]  core_rdata;
    logic [7:0]  ram_rdata;
    logic [6:0]  rd_addr_a;
    logic [6:0]  rd_addr_b;
    logic [15:0] rd_a;
    logic [15:0] rd_b;
    logic [15:0] op_b;
    logic [15:0] alu_result;
    logic        carry;
    logic        alu_carry;

    tiny16_core #(
        .RAM_BITS(RAM_BITS)
    ) u_core (
        .clk         (clk),
        .nreset      (nreset),
        .core_gnt    (core_gnt),
        .core_rvalid (core_rvalid),
        .core_rdata  (core_rdata),
        .rd_a        (rd_a),
        .rd_b        (rd_b),
        .alu_result  (alu_result),
        .alu_carry   (alu_carry),
        .interrupt   (interrupt),
        .core_req    (core_req),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .reg_wr      (reg_wr),
        .alu_op      (alu_op),
        .op_b        (op_b),
        .carry       (carry),
        .io_out      (io_out),
        .hlt         (hlt),
        .wfi         (wfi),
        .error       (error),
        .in_interrupt(in_interrupt)
    );

    // Stack register tap is not brought out.
    tiny16_regs u_regs (
        .clk      (clk),
        .rd_addr_a(rd_addr_a),
        .rd_addr_b(rd_addr_b),
        .wr       (reg_wr),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .sp       ()
    );

    tiny16_alu u_alu (
        .alu_op   (alu_op),
        .op_a     (rd_a),
        .op_b     (op_b),
        .carry_in (carry),
        .data_in  (data_in),
        .result   (alu_result),
        .carry_out(alu_carry)
    );

    ram_arbiter #(
        .RAM_BITS(RAM_BITS)
    ) u_arbiter (
        .clk        (clk),
        .nreset     (nreset),
        .host_req   (host_req),
        .core_req   (core_req),
        .ram_rdata  (ram_rdata),
        .ram_req    (ram_req),
        .core_gnt   (core_gnt),
        .core_rvalid(core_rvalid),
        .core_rdata (core_rdata)
    );

    code_ram #(
        .RAM_BITS(RAM_BITS)
    ) u_ram (
        .clk  (clk),
        .req  (ram_req),
        .rdata(ram_rdata)
    );

endmodule

`default_nettype wire

// ==== hw/ram_arbiter.sv ====
`default_nettype none

module ram_arbiter #(
    parameter int RAM_BITS = 13
) (
    input  wire                       clk,
    input  wire                       nreset,
    input  wire tiny16_pkg::ram_req_t host_req,
    input  wire tiny16_pkg::ram_req_t core_req,
    input  wire [7:0]                 ram_rdata,
    output tiny16_pkg::ram_req_t      ram_req,
    output logic                      core_gnt,
    output logic                      core_rvalid,
    output logic [7:0]                core_rdata
);
    import tiny16_pkg::*;

    ram_req_t sel;

    // Host first.
    assign sel      = host_req.valid ? host_req : core_req;
    assign core_gnt = core_req.valid && !host_req.valid;

    always_comb begin
        ram_req      = sel;
        ram_req.addr = RAM_ADDR_W'(sel.addr[RAM_BITS-1:0]);
    end

    // Read in flight belongs to the core.
    always_ff @(posedge clk) begin
        if (!nreset) begin
            core_rvalid <= 1'b0;
        end else begin
            core_rvalid <= core_gnt;
        end
    end

    assign core_rdata = ram_rdata;

endmodule

`default_nettype wire

// ==== hw/code_ram.sv ====
`default_nettype none

module code_ram #(
    parameter int RAM_BITS = 13
) (
    input  wire                       clk,
    input  wire tiny16_pkg::ram_req_t req,
    output logic [7:0]                rdata
);

    logic [7:0] mem [2**RAM_BITS];

    // Write or read, one per cycle.
    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.write) begin
                mem[req.addr[RAM_BITS-1:0]] <= req.wdata;
            end else begin
                rdata <= mem[req.addr[RAM_BITS-1:0]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/tiny16_core.sv ====
`default_nettype none

module tiny16_core #(
    parameter int RAM_BITS = 13
) (
    input  wire                  clk,
    input  wire                  nreset,
    input  wire                  core_gnt,
    input  wire                  core_rvalid,
    input  wire [7:0]            core_rdata,
    input  wire [15:0]           rd_a,
    input  wire [15:0]           rd_b,
    input  wire [15:0]           alu_result,
    input  wire                  alu_carry,
    input  wire                  interrupt,
    output tiny16_pkg::ram_req_t core_req,
    output logic [6:0]           rd_addr_a,
    output logic [6:0]           rd_addr_b,
    output tiny16_pkg::reg_wr_t  reg_wr,
    output tiny16_pkg::alu_op_e  alu_op,
    output logic [15:0]          op_b,
    output logic                 carry,
    output tiny16_pkg::io_out_t  io_out,
    output logic                 hlt,
    output logic                 wfi,
    output logic                 error,
    output logic                 in_interrupt
);
    import tiny16_pkg::*;

    // Low bits of a SYS opcode.
    typedef enum logic [1:0] {
        SYS_HLT,
        SYS_WFI,
        SYS_RETI,
        SYS_BAD
    } sys_op_e;

    core_state_e state;
    op_class_e   cls;
    op_class_e   new_cls;
    sys_op_e     sys_op;
    flags_t      flags;
    logic [7:0]  instr;
    logic [15:0] pc;
    logic [15:0] acc;
    logic [15:0] opnd;
    logic [6:0]  dst;
    logic        second;
    logic        irq_req;
    logic        fetching;
    logic        take_br;
    logic        no_wb;

    assign cls      = op_class_e'(instr[7:5]);
    assign new_cls  = op_class_e'(core_rdata[7:5]);
    assign sys_op   = sys_op_e'(instr[1:0]);
    assign alu_op   = alu_op_e'(instr[4:0]);
    assign carry    = flags.c;
    assign no_wb    = alu_op == ALU_CMP || alu_op == ALU_TEST;
    assign fetching = (state == FETCH && !irq_req) || state == OPER1 || state == OPER2;

    // Mask picks c, z, n and bit 3 inverts.
    assign take_br = (|(instr[2:0] & {flags.c, flags.z, flags.n})) ^ instr[3];

    // ****************************************
    // Code RAM and register file ports.
    // ****************************************

    // pc doubles as the fetch pointer.
    always_comb begin
        core_req       = '0;
        core_req.valid = fetching && !core_rvalid;
        core_req.addr  = RAM_ADDR_W'(pc[RAM_BITS-1:0]);
    end

    always_comb begin
        rd_addr_a = dst;
        rd_addr_b = opnd[6:0];
        if (state == FETCH) begin
            rd_addr_a = SP_INDEX;
        end else if (state == OPER1 && core_rvalid) begin
            rd_addr_a = core_rdata[6:0];
        end
        if (state == OPER2 && core_rvalid) begin
            rd_addr_b = core_rdata[6:0];
        end
    end

    // Return address lives in the stack register.
    always_comb begin
        reg_wr = '0;
        if (state == WRITE) begin
            reg_wr.en   = 1'b1;
            reg_wr.addr = dst;
            reg_wr.data = acc;
        end else if (state == FETCH && irq_req) begin
            reg_wr.en   = 1'b1;
            reg_wr.addr = SP_INDEX;
            reg_wr.data = pc;
        end
    end

    always_comb begin
        case (cls)
            ALU_REG:  op_b = rd_b;
            ALU_IMM8: op_b = {{8{opnd[7]}}, opnd[7:0]};
            default:  op_b = opnd;
        endcase
    end

    // ****************************************
    // Sequencer.
    // ****************************************

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state         <= FETCH;
            pc            <= '0;
            instr         <= '0;
            flags         <= '0;
            second        <= 1'b0;
            irq_req       <= 1'b0;
            in_interrupt  <= 1'b0;
            hlt           <= 1'b0;
            wfi           <= 1'b0;
            error         <= 1'b0;
            io_out.strobe <= 1'b0;
        end else begin
            io_out.strobe <= 1'b0;
            // Frozen once FETCH is reached, so it holds the boundary sample.
            if (state != FETCH) begin
                irq_req <= interrupt && !in_interrupt;
            end
            if (core_req.valid && core_gnt) begin
                pc <= pc + 16'd1;
            end
            case (state)
                FETCH: begin
                    if (irq_req) begin
                        pc           <= IRQ_VECTOR;
                        in_interrupt <= 1'b1;
                        irq_req      <= 1'b0;
                    end else if (core_rvalid) begin
                        instr <= core_rdata;
                        state <= (new_cls == SYS || new_cls == BAD) ? EXEC : OPER1;
                    end
                end
                OPER1: begin
                    if (core_rvalid) begin
                        dst  <= core_rdata[6:0];
                        opnd <= {opnd[7:0], core_rdata};
                        if (cls == BR || (cls == ALU_REG && !instr[4])) begin
                            state <= EXEC;
                        end else begin
                            state <= OPER2;
                        end
                    end
                end
                OPER2: begin
                    // Immediate 16 takes two bytes here.
                    if (core_rvalid) begin
                        opnd   <= {opnd[7:0], core_rdata};
                        second <= cls == ALU_IMM16 && !second;
                        if (cls != ALU_IMM16 || second) begin
                            state <= EXEC;
                        end
                    end
                end
                EXEC: begin
                    state <= FETCH;
                    case (cls)
                        ALU_REG, ALU_IMM8, ALU_IMM16: begin
                            acc     <= alu_result;
                            flags.c <= alu_carry;
                            flags.z <= alu_result == 16'd0;
                            flags.n <= alu_result[15];
                            if (!no_wb) begin
                                state <= WRITE;
                            end
                        end
                        OUT: begin
                            io_out.strobe  <= 1'b1;
                            io_out.address <= opnd[15:8];
                            io_out.data    <= rd_b;
                        end
                        JMP: pc <= opnd;
                        BR: begin
                            if (take_br) begin
                                pc <= pc + {{8{opnd[7]}}, opnd[7:0]};
                            end
                        end
                        SYS: begin
                            case (sys_op)
                                SYS_HLT: begin
                                    hlt   <= 1'b1;
                                    state <= STOP;
                                end
                                SYS_WFI: begin
                                    wfi   <= 1'b1;
                                    state <= WAIT;
                                end
                                SYS_RETI: begin
                                    pc           <= rd_a;
                                    in_interrupt <= 1'b0;
                                end
                                SYS_BAD: begin
                                    error <= 1'b1;
                                    state <= STOP;
                                end
                            endcase
                        end
                        default: begin
                            error <= 1'b1;
                            state <= STOP;
                        end
                    endcase
                end
                WRITE: state <= FETCH;
                WAIT: begin
                    if (interrupt) begin
                        wfi   <= 1'b0;
                        state <= FETCH;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/tiny16_regs.sv ====
`default_nettype none

module tiny16_regs (
    input  wire                      clk,
    input  wire [6:0]                rd_addr_a,
    input  wire [6:0]                rd_addr_b,
    input  wire tiny16_pkg::reg_wr_t wr,
    output logic [15:0]              rd_a,
    output logic [15:0]              rd_b,
    output logic [15:0]              sp
);
    import tiny16_pkg::*;

    logic [15:0] regs_q [128];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            regs_q[wr.addr] <= wr.data;
        end
        // Same cycle write is forwarded.
        rd_a <= (wr.en && wr.addr == rd_addr_a) ? wr.data : regs_q[rd_addr_a];
        rd_b <= (wr.en && wr.addr == rd_addr_b) ? wr.data : regs_q[rd_addr_b];
    end

    assign sp = regs_q[SP_INDEX];

endmodule

`default_nettype wire

// ==== hw/tiny16_alu.sv ====
`default_nettype none

module tiny16_alu (
    input  wire tiny16_pkg::alu_op_e alu_op,
    input  wire [15:0]               op_a,
    input  wire [15:0]               op_b,
    input  wire                      carry_in,
    input  wire [15:0]               data_in,
    output logic [15:0]              result,
    output logic                     carry_out
);
    import tiny16_pkg::*;

    always_comb begin
        result    = op_a;
        carry_out = carry_in;
        case (alu_op)
            // Single operand group.
            ALU_CLR: result = '0;
            ALU_SET: result = '1;
            ALU_INC: result = op_a + 16'd1;
            ALU_DEC: result = op_a - 16'd1;
            ALU_NOT: result = ~op_a;
            ALU_NEG: result = -op_a;
            // Shifts and rotates go through the carry.
            ALU_SHL: {carry_out, result} = {op_a, 1'b0};
            ALU_SHR: {result, carry_out} = {1'b0, op_a};
            ALU_ROL: {carry_out, result} = {op_a, carry_in};
            ALU_ROR: {result, carry_out} = {carry_in, op_a};
            ALU_IN:  result = data_in;
            // Two operand group.
            ALU_MOV: result = op_b;
            ALU_ADD: begin
                {carry_out, result} = {1'b0, op_a} + {1'b0, op_b};
            end
            ALU_ADC: begin
                {carry_out, result} = {1'b0, op_a} + {1'b0, op_b} + 17'(carry_in);
            end
            // Carry set means borrow.
            ALU_SUB, ALU_CMP: begin
                {carry_out, result} = {1'b0, op_a} - {1'b0, op_b};
            end
            ALU_SBC: begin
                {carry_out, result} = {1'b0, op_a} - {1'b0, op_b} - 17'(carry_in);
            end
            ALU_AND, ALU_TEST: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/tiny16_pkg.sv ====
`default_nettype none

package tiny16_pkg;

    // ****************************************
    // Widths and fixed locations.
    // ****************************************

    // Widest code RAM address the request struct carries.
    localparam int RAM_ADDR_W = 13;

    localparam logic [6:0] SP_INDEX = 7'd127;
    localparam logic [15:0] IRQ_VECTOR = 16'd3;

    // ****************************************
    // Encodings.
    // ****************************************

    // Low five bits of an ALU class instruction.
    typedef enum logic [4:0] {
        ALU_CLR  = 5'd0,
        ALU_SET  = 5'd1,
        ALU_INC  = 5'd2,
        ALU_DEC  = 5'd3,
        ALU_NOT  = 5'd4,
        ALU_NEG  = 5'd5,
        ALU_SHL  = 5'd6,
        ALU_SHR  = 5'd7,
        ALU_ROL  = 5'd8,
        ALU_ROR  = 5'd9,
        ALU_IN   = 5'd10,
        ALU_MOV  = 5'd16,
        ALU_ADC  = 5'd17,
        ALU_ADD  = 5'd18,
        ALU_SBC  = 5'd19,
        ALU_SUB  = 5'd20,
        ALU_AND  = 5'd21,
        ALU_OR   = 5'd22,
        ALU_XOR  = 5'd23,
        ALU_CMP  = 5'd30,
        ALU_TEST = 5'd31
    } alu_op_e;

    // Bits 7:5 of the opcode byte.
    typedef enum logic [2:0] {
        ALU_REG,
        ALU_IMM8,
        ALU_IMM16,
        OUT,
        JMP,
        BR,
        SYS,
        BAD
    } op_class_e;

    typedef enum logic [2:0] {
        FETCH,
        OPER1,
        OPER2,
        EXEC,
        WRITE,
        WAIT,
        STOP
    } core_state_e;

    // ****************************************
    // Bundles.
    // ****************************************

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [RAM_ADDR_W-1:0] addr;
        logic [7:0]            wdata;
    } ram_req_t;

    typedef struct packed {
        logic        en;
        logic [6:0]  addr;
        logic [15:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic        strobe;
        logic [7:0]  address;
        logic [15:0] data;
    } io_out_t;

    typedef struct packed {
        logic c;
        logic z;
        logic n;
    } flags_t;

endpackage

`default_nettype wire
